// File: Bender.yml
package:
  name: mips_pipe

sources:
  - target: any(rtl, test)
    include_dirs:
      - rtl
    files:
      - rtl/cpuPkg.sv
      - rtl/pcUnit.sv
      - rtl/controlUnit.sv
      - rtl/regFile.sv
      - rtl/alu.sv
      - rtl/cpu.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/tbClock.sv
      - verification/cpuTb.sv

// File: flist.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/pcUnit.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/alu.sv
rtl/cpu.sv
verification/tbClock.sv
verification/cpuTb.sv

// File: rtl/alu.sv
// Execute-stage ALU for add, sub, and, or and signed slt, with a zero flag for beq.
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module alu (
  input  cpuPkg::aluCmd_e cmd,
  input  cpuPkg::word_t   operandA,
  input  cpuPkg::word_t   operandB,
  output cpuPkg::word_t   result,
  output logic            zero
);

  logic lessThan;

  // Signed compare for slt.
  assign lessThan = $signed(operandA) < $signed(operandB);

  always_comb begin
    case (cmd)
      cpuPkg::aluAdd: result = operandA + operandB;
      cpuPkg::aluSub: result = operandA - operandB;
      cpuPkg::aluAnd: result = operandA & operandB;
      cpuPkg::aluOr:  result = operandA | operandB;
      cpuPkg::aluSlt: result = {{(`CPU_XLEN-1){1'b0}}, lessThan};
      default:        result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: rtl/controlUnit.sv
// Main decoder; turns the opcode and function fields of a decode-stage instruction into controls.
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
  input  cpuPkg::instr_u instr,
  output cpuPkg::ctrl_s  ctrl
);

  always_comb begin
    // Anything not recognised below runs as a nop.
    ctrl = '0;

    case (instr.rType.opcode)
      cpuPkg::opRtype: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (instr.rType.funct)
          cpuPkg::functAdd: ctrl.aluCmd = cpuPkg::aluAdd;
          cpuPkg::functSub: ctrl.aluCmd = cpuPkg::aluSub;
          cpuPkg::functAnd: ctrl.aluCmd = cpuPkg::aluAnd;
          cpuPkg::functOr:  ctrl.aluCmd = cpuPkg::aluOr;
          cpuPkg::functSlt: ctrl.aluCmd = cpuPkg::aluSlt;
          default: begin
            ctrl = '0;
          end
        endcase
      end
      cpuPkg::opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluCmd   = cpuPkg::aluAdd;
      end
      cpuPkg::opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluCmd   = cpuPkg::aluAdd;
      end
      cpuPkg::opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluCmd   = cpuPkg::aluAdd;
      end
      cpuPkg::opBeq: begin
        // Equal operands give a zero difference.
        ctrl.branch = 1'b1;
        ctrl.aluCmd = cpuPkg::aluSub;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/cpu.sv
// Top of the five-stage core; connect an instruction memory and a data memory that answer combinationally.
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu (
  input  logic          clk,
  input  logic          rst,
  output cpuPkg::word_t instrAddr,
  input  cpuPkg::word_t instr,
  output cpuPkg::word_t dataAddr,
  output cpuPkg::word_t dataWData,
  output logic          dataWriteEnable,
  input  cpuPkg::word_t dataRData
);

  // Stage registers.
  cpuPkg::ifId_s  ifId;
  cpuPkg::idEx_s  idEx;
  cpuPkg::exMem_s exMem;
  cpuPkg::memWb_s memWb;

  // Fetch.
  cpuPkg::word_t   pcPlus4F;
  logic            branchTaken;

  // Decode.
  cpuPkg::ctrl_s   ctrlD;
  cpuPkg::word_t   readData1D;
  cpuPkg::word_t   readData2D;
  cpuPkg::word_t   signImmD;

  // Execute.
  cpuPkg::word_t   operandBE;
  cpuPkg::word_t   aluResultE;
  logic            aluZeroE;
  cpuPkg::regIdx_t writeRegE;
  cpuPkg::word_t   branchTargetE;

  // Write-back.
  cpuPkg::word_t   wbData;

  // IF

  // Branch resolves in the memory stage.
  assign branchTaken = exMem.ctrl.branch & exMem.zero;

  pcUnit i_pcUnit (
    .clk          (clk),
    .rst          (rst),
    .branchTaken  (branchTaken),
    .branchTarget (exMem.branchTarget),
    .pc           (instrAddr),
    .pcPlus4      (pcPlus4F)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ifId <= '0;
    end else begin
      ifId.instr   <= instr;
      ifId.pcPlus4 <= pcPlus4F;
    end
  end

  // ID

  controlUnit i_controlUnit (
    .instr (ifId.instr),
    .ctrl  (ctrlD)
  );

  regFile i_regFile (
    .clk         (clk),
    .rst         (rst),
    .readAddr1   (ifId.instr.rType.rs),
    .readAddr2   (ifId.instr.rType.rt),
    .writeAddr   (memWb.writeReg),
    .writeEnable (memWb.regWrite),
    .writeData   (wbData),
    .readData1   (readData1D),
    .readData2   (readData2D)
  );

  assign signImmD = {{(`CPU_XLEN-16){ifId.instr.iType.imm[15]}}, ifId.instr.iType.imm};

  always_ff @(posedge clk) begin
    if (rst) begin
      idEx <= '0;
    end else begin
      idEx.ctrl      <= ctrlD;
      idEx.readData1 <= readData1D;
      idEx.readData2 <= readData2D;
      idEx.rt        <= ifId.instr.rType.rt;
      idEx.rd        <= ifId.instr.rType.rd;
      idEx.signImm   <= signImmD;
      idEx.pcPlus4   <= ifId.pcPlus4;
    end
  end

  // EX

  // Immediate forms write rt, register forms write rd.
  assign writeRegE = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
  assign operandBE = idEx.ctrl.aluSrc ? idEx.signImm : idEx.readData2;

  alu i_alu (
    .cmd      (idEx.ctrl.aluCmd),
    .operandA (idEx.readData1),
    .operandB (operandBE),
    .result   (aluResultE),
    .zero     (aluZeroE)
  );

  // Word offset relative to the slot after the branch.
  assign branchTargetE = idEx.pcPlus4 + (idEx.signImm << 2);

  always_ff @(posedge clk) begin
    if (rst) begin
      exMem <= '0;
    end else begin
      exMem.ctrl         <= idEx.ctrl;
      exMem.zero         <= aluZeroE;
      exMem.aluOut       <= aluResultE;
      exMem.storeData    <= idEx.readData2;
      exMem.writeReg     <= writeRegE;
      exMem.branchTarget <= branchTargetE;
    end
  end

  // MEM

  assign dataAddr        = exMem.aluOut;
  assign dataWData       = exMem.storeData;
  assign dataWriteEnable = exMem.ctrl.memWrite;

  always_ff @(posedge clk) begin
    if (rst) begin
      memWb <= '0;
    end else begin
      memWb.regWrite <= exMem.ctrl.regWrite;
      memWb.memToReg <= exMem.ctrl.memToReg;
      memWb.aluOut   <= exMem.aluOut;
      memWb.loadData <= dataRData;
      memWb.writeReg <= exMem.writeReg;
    end
  end

  // WB

  // Loads take memory data, everything else the ALU result.
  assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluOut;

endmodule

`default_nettype wire

// File: rtl/cpuPkg.sv
// Types shared by the pipelined core: words, opcodes, instruction views and stage registers.
`default_nettype none

`include "cpu_defines.svh"

package cpuPkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdx_t;

  // Major opcodes, MIPS encoding.
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcode_e;

  // Function field of register-form instructions.
  typedef enum logic [5:0] {
    functAdd = 6'h20,
    functSub = 6'h22,
    functAnd = 6'h24,
    functOr  = 6'h25,
    functSlt = 6'h2a
  } funct_e;

  // ALU commands. Add is zero so a cleared control word is harmless.
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluSlt = 3'd3,
    aluAnd = 3'd4,
    aluOr  = 3'd7
  } aluCmd_e;

  // One instruction word, seen as register form or immediate form.
  typedef union packed {
    struct packed {
      opcode_e    opcode;
      regIdx_t    rs;
      regIdx_t    rt;
      regIdx_t    rd;
      logic [4:0] shamt;
      funct_e     funct;
    } rType;
    struct packed {
      opcode_e     opcode;
      regIdx_t     rs;
      regIdx_t     rt;
      logic [15:0] imm;
    } iType;
  } instr_u;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    memWrite;
    logic    branch;
    aluCmd_e aluCmd;
    logic    aluSrc;
    logic    regDst;
  } ctrl_s;

  typedef struct packed {
    instr_u instr;
    word_t  pcPlus4;
  } ifId_s;

  typedef struct packed {
    ctrl_s   ctrl;
    word_t   readData1;
    word_t   readData2;
    regIdx_t rt;
    regIdx_t rd;
    word_t   signImm;
    word_t   pcPlus4;
  } idEx_s;

  typedef struct packed {
    ctrl_s   ctrl;
    logic    zero;
    word_t   aluOut;
    word_t   storeData;
    regIdx_t writeReg;
    word_t   branchTarget;
  } exMem_s;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    word_t   aluOut;
    word_t   loadData;
    regIdx_t writeReg;
  } memWb_s;

endpackage

`default_nettype wire

// File: rtl/cpu_defines.svh
// Core-wide sizing macros; include this wherever the word width, register count or reset PC is needed.
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width in bits.
`define CPU_XLEN 32

// Number of architectural registers.
`define CPU_REG_COUNT 32

// First fetch address once reset is released.
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: rtl/pcUnit.sv
// Program counter of the core; steps by four each cycle or jumps to a resolved branch target.
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module pcUnit (
  input  logic          clk,
  input  logic          rst,
  input  logic          branchTaken,
  input  cpuPkg::word_t branchTarget,
  output cpuPkg::word_t pc,
  output cpuPkg::word_t pcPlus4
);

  // Sequential successor, also carried down the pipe for branch arithmetic.
  assign pcPlus4 = pc + cpuPkg::word_t'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `CPU_RESET_PC;
    end else if (branchTaken) begin
      // Branch from the memory stage wins.
      pc <= branchTarget;
    end else begin
      pc <= pcPlus4;
    end
  end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
// Register file with two read ports and one write port; same-cycle writes pass through to reads.
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module regFile (
  input  logic            clk,
  input  logic            rst,
  input  cpuPkg::regIdx_t readAddr1,
  input  cpuPkg::regIdx_t readAddr2,
  input  cpuPkg::regIdx_t writeAddr,
  input  logic            writeEnable,
  input  cpuPkg::word_t   writeData,
  output cpuPkg::word_t   readData1,
  output cpuPkg::word_t   readData2
);

  logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];
  logic                 writeLive;

  // Register zero is never written, so it stays at its reset value.
  assign writeLive = writeEnable && (writeAddr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeLive) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Write-back bypass into decode.
  assign readData1 = (writeLive && writeAddr == readAddr1) ? writeData : regs[readAddr1];
  assign readData2 = (writeLive && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

`default_nettype wire

// File: verification/cpuTb.sv
// Testbench top for the core; runs directed and random programs and checks fetches and stores.
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpuTb;

  typedef struct packed {
    int            cycle;
    cpuPkg::word_t addr;
    cpuPkg::word_t data;
  } store_s;

  typedef struct packed {
    cpuPkg::word_t addr;
    cpuPkg::word_t data;
  } preload_s;

  localparam int memWords = 256;

  logic          clk;
  logic          rst;
  cpuPkg::word_t instrAddr;
  cpuPkg::word_t instr;
  cpuPkg::word_t dataAddr;
  cpuPkg::word_t dataWData;
  logic          dataWriteEnable;
  cpuPkg::word_t dataRData;

  cpuPkg::word_t imem [memWords];
  cpuPkg::word_t dmem [memWords];
  cpuPkg::word_t refRegs [`CPU_REG_COUNT];
  cpuPkg::word_t refMem [memWords];
  cpuPkg::word_t prog [$];
  preload_s      preloads [$];
  cpuPkg::word_t expFetch [$];
  store_s        expStores [$];
  int            errors;
  int            checks;
  longint        budget;

  tbClock i_clock (.clk(clk));

  cpu i_dut (
    .clk             (clk),
    .rst             (rst),
    .instrAddr       (instrAddr),
    .instr           (instr),
    .dataAddr        (dataAddr),
    .dataWData       (dataWData),
    .dataWriteEnable (dataWriteEnable),
    .dataRData       (dataRData)
  );

  // Fetches past the array read as nop.
  assign instr     = (instrAddr < memWords * 4) ? imem[instrAddr[9:2]] : '0;
  assign dataRData = dmem[dataAddr[9:2]];

  always @(posedge clk) begin
    if (dataWriteEnable) begin
      dmem[dataAddr[9:2]] <= dataWData;
    end
  end

  task automatic compareWord(input string name, input cpuPkg::word_t exp,
                             input cpuPkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic compareAddr(input string name, input cpuPkg::word_t exp,
                             input cpuPkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic compareBit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  function automatic cpuPkg::word_t rForm(cpuPkg::funct_e funct, int rd, int rs, int rt);
    cpuPkg::instr_u w;
    w = '0;
    w.rType.opcode = cpuPkg::opRtype;
    w.rType.rs     = cpuPkg::regIdx_t'(rs);
    w.rType.rt     = cpuPkg::regIdx_t'(rt);
    w.rType.rd     = cpuPkg::regIdx_t'(rd);
    w.rType.funct  = funct;
    return cpuPkg::word_t'(w);
  endfunction

  // Arguments in assembler order, rt before rs.
  function automatic cpuPkg::word_t iForm(cpuPkg::opcode_e op, int rt, int rs, int imm);
    cpuPkg::instr_u w;
    w.iType.opcode = op;
    w.iType.rs     = cpuPkg::regIdx_t'(rs);
    w.iType.rt     = cpuPkg::regIdx_t'(rt);
    w.iType.imm    = imm[15:0];
    return cpuPkg::word_t'(w);
  endfunction

  function automatic void nops(int n);
    repeat (n) prog.push_back('0);
  endfunction

  // Register-form op, two nops, then a store of its result.
  function automatic void opStore(cpuPkg::funct_e funct, int rd, int rs, int rt, int addr);
    prog.push_back(rForm(funct, rd, rs, rt));
    nops(2);
    prog.push_back(iForm(cpuPkg::opSw, rd, 0, addr));
  endfunction

  function automatic cpuPkg::word_t fillWord(int idx);
    cpuPkg::word_t addr;
    addr = cpuPkg::word_t'(idx) << 2;
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_0f96;
  endfunction

  // ISA-level model of one instruction; returns 1 for a taken beq.
  function automatic bit modelStep(input cpuPkg::word_t pc, input int cycle,
                                   output cpuPkg::word_t target);
    cpuPkg::instr_u ins;
    cpuPkg::word_t  a;
    cpuPkg::word_t  b;
    cpuPkg::word_t  imm;
    cpuPkg::word_t  ea;
    cpuPkg::word_t  res;
    int             dst;
    bit             wr;
    bit             taken;
    ins    = (pc / 4 < prog.size()) ? prog[pc / 4] : '0;
    a      = refRegs[ins.rType.rs];
    b      = refRegs[ins.rType.rt];
    imm    = {{16{ins.iType.imm[15]}}, ins.iType.imm};
    ea     = a + imm;
    target = pc + 4 + (imm << 2);
    dst    = ins.iType.rt;
    res    = '0;
    wr     = 1'b0;
    taken  = 1'b0;
    case (ins.rType.opcode)
      cpuPkg::opRtype: begin
        wr  = 1'b1;
        dst = ins.rType.rd;
        case (ins.rType.funct)
          cpuPkg::functAdd: res = a + b;
          cpuPkg::functSub: res = a - b;
          cpuPkg::functAnd: res = a & b;
          cpuPkg::functOr:  res = a | b;
          cpuPkg::functSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:          wr = 1'b0;
        endcase
      end
      cpuPkg::opAddi: begin
        wr  = 1'b1;
        res = ea;
      end
      cpuPkg::opLw: begin
        wr  = 1'b1;
        res = refMem[ea[9:2]];
      end
      cpuPkg::opSw: begin
        refMem[ea[9:2]] = b;
        expStores.push_back(store_s'{cycle: cycle + 3, addr: ea, data: b});
      end
      cpuPkg::opBeq: taken = (a == b);
      default: ;
    endcase
    if (wr && dst != 0) begin
      refRegs[dst] = res;
    end
    return taken;
  endfunction

  // Expected fetch address per cycle; a taken beq redirects fetch four cycles later.
  task automatic buildExpected();
    cpuPkg::word_t pc;
    cpuPkg::word_t target;
    cpuPkg::word_t pendTarget;
    int            pendCycle;
    int            cycle;
    expFetch.delete();
    expStores.delete();
    foreach (refRegs[i]) refRegs[i] = '0;
    foreach (refMem[i]) refMem[i] = fillWord(i);
    foreach (preloads[i]) refMem[preloads[i].addr[9:2]] = preloads[i].data;
    pc         = `CPU_RESET_PC;
    pendTarget = '0;
    pendCycle  = -1;
    cycle      = 0;
    while ((pc < prog.size() * 4 || pendCycle > cycle) && cycle < 40 * prog.size()) begin
      expFetch.push_back(pc);
      if (modelStep(pc, cycle, target)) begin
        pendTarget = target;
        pendCycle  = cycle + 4;
      end
      cycle++;
      pc = (cycle == pendCycle) ? pendTarget : pc + 4;
    end
    // Drain so the last store reaches the data port.
    repeat (4) begin
      expFetch.push_back(pc);
      pc += 4;
    end
  endtask

  task automatic runProgram(input string label);
    buildExpected();
    budget += 40 * prog.size() + 16;
    @(negedge clk);
    rst = 1'b1;
    foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : '0;
    foreach (dmem[i]) dmem[i] = fillWord(i);
    foreach (preloads[i]) dmem[preloads[i].addr[9:2]] = preloads[i].data;
    repeat (16) begin
      @(negedge clk);
      compareBit("dataWriteEnable", 1'b0, dataWriteEnable);
      compareAddr("instrAddr", `CPU_RESET_PC, instrAddr);
    end
    rst = 1'b0;
    for (int cycle = 0; cycle < expFetch.size(); cycle++) begin
      if (cycle > 0) begin
        @(negedge clk);
      end
      compareAddr("instrAddr", expFetch[cycle], instrAddr);
      if (dataWriteEnable === 1'b1) begin
        if (expStores.size() > 0 && expStores[0].cycle == cycle) begin
          compareAddr("dataAddr", expStores[0].addr, dataAddr);
          compareWord("dataWData", expStores[0].data, dataWData);
          void'(expStores.pop_front());
        end else begin
          errors++;
          $display("%s: unexpected store to 0x%08h in cycle %0d", label, dataAddr, cycle);
        end
      end else if (expStores.size() > 0 && expStores[0].cycle == cycle) begin
        errors++;
        $display("%s: store to 0x%08h due in cycle %0d never arrived",
                 label, expStores[0].addr, cycle);
        void'(expStores.pop_front());
      end
    end
    foreach (expStores[i]) begin
      errors++;
      $display("%s: store to 0x%08h was never seen", label, expStores[i].addr);
    end
    prog.delete();
    preloads.delete();
  endtask

  task automatic resetThenFetch();
    prog.push_back(iForm(cpuPkg::opAddi, 1, 0, 3));
    nops(2);
    prog.push_back(iForm(cpuPkg::opSw, 1, 0, 32'h10));
    runProgram("reset");
  endtask

  task automatic registerArith();
    prog.push_back(iForm(cpuPkg::opAddi, 1, 0, 25));
    prog.push_back(iForm(cpuPkg::opAddi, 2, 0, -7));
    prog.push_back(iForm(cpuPkg::opAddi, 3, 0, -20));
    nops(2);
    opStore(cpuPkg::functAdd, 4, 1, 2, 32'h00);
    opStore(cpuPkg::functSub, 5, 1, 2, 32'h04);
    opStore(cpuPkg::functAnd, 6, 1, 2, 32'h08);
    opStore(cpuPkg::functOr, 7, 1, 2, 32'h0c);
    opStore(cpuPkg::functSlt, 8, 2, 1, 32'h10);
    opStore(cpuPkg::functSlt, 9, 1, 2, 32'h14);
    // Both operands negative.
    opStore(cpuPkg::functSlt, 10, 2, 3, 32'h18);
    opStore(cpuPkg::functSlt, 11, 3, 2, 32'h1c);
    opStore(cpuPkg::functAdd, 0, 1, 2, 32'h20);
    runProgram("arith");
  endtask

  task automatic immediateTiming();
    prog.push_back(iForm(cpuPkg::opAddi, 1, 0, -1));
    prog.push_back(iForm(cpuPkg::opAddi, 2, 0, -32768));
    prog.push_back(iForm(cpuPkg::opAddi, 3, 0, 32'h7fff));
    nops(2);
    prog.push_back(iForm(cpuPkg::opAddi, 4, 1, -100));
    nops(2);
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(iForm(cpuPkg::opSw, r, 0, 32'h3c + 4 * r));
    end
    runProgram("immediates");
  endtask

  task automatic loadStoreRoundTrip();
    preloads.push_back(preload_s'{addr: 32'h80, data: 32'h1234_5678});
    preloads.push_back(preload_s'{addr: 32'h84, data: 32'h8000_0001});
    prog.push_back(iForm(cpuPkg::opAddi, 10, 0, 32'h80));
    nops(2);
    prog.push_back(iForm(cpuPkg::opLw, 1, 10, 0));
    prog.push_back(iForm(cpuPkg::opLw, 2, 10, 4));
    nops(1);
    prog.push_back(iForm(cpuPkg::opAddi, 3, 1, 5));
    prog.push_back(iForm(cpuPkg::opAddi, 4, 2, -3));
    prog.push_back(iForm(cpuPkg::opSw, 1, 10, -4));
    prog.push_back(iForm(cpuPkg::opSw, 3, 10, 32'h20));
    prog.push_back(iForm(cpuPkg::opSw, 4, 10, 32'h2c));
    runProgram("load/store");
  endtask

  task automatic branchSlots();
    prog.push_back(iForm(cpuPkg::opAddi, 1, 0, 7));
    prog.push_back(iForm(cpuPkg::opAddi, 2, 0, 7));
    prog.push_back(iForm(cpuPkg::opAddi, 3, 0, 5));
    nops(2);
    // Taken branch to the sixth word after the beq.
    prog.push_back(iForm(cpuPkg::opBeq, 2, 1, 5));
    for (int k = 0; k < 6; k++) begin
      prog.push_back(iForm(cpuPkg::opSw, 1 + k % 3, 0, 32'h100 + 4 * k));
    end
    // Not taken.
    prog.push_back(iForm(cpuPkg::opBeq, 3, 1, 6));
    for (int k = 0; k < 4; k++) begin
      prog.push_back(iForm(cpuPkg::opSw, 1 + k % 3, 0, 32'h120 + 4 * k));
    end
    runProgram("branch");
  endtask

  task automatic randomOperands();
    cpuPkg::funct_e ops [5];
    int             base;
    ops = '{cpuPkg::functAdd, cpuPkg::functSub, cpuPkg::functAnd,
            cpuPkg::functOr, cpuPkg::functSlt};
    for (int k = 0; k < 20; k++) begin
      base = 32'h200 + 8 * k;
      preloads.push_back(preload_s'{addr: base, data: $urandom()});
      preloads.push_back(preload_s'{addr: base + 4, data: $urandom()});
      prog.push_back(iForm(cpuPkg::opLw, 1, 0, base));
      prog.push_back(iForm(cpuPkg::opLw, 2, 0, base + 4));
      nops(2);
      opStore(ops[$urandom_range(4, 0)], 3, 1, 2, 32'h300 + 4 * k);
    end
    runProgram("random");
  endtask

  initial begin
    void'($urandom(32'hd8766bb8));
    errors = 0;
    checks = 0;
    budget = 0;
    rst    = 1'b1;
    foreach (imem[i]) imem[i] = '0;
    foreach (dmem[i]) dmem[i] = fillWord(i);
    resetThenFetch();
    registerArith();
    immediateTiming();
    loadStoreRoundTrip();
    branchSlots();
    randomOperands();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Each test raises the cycle allowance when it starts.
  initial begin
    longint elapsed;
    elapsed = 0;
    while (elapsed <= budget) begin
      @(posedge clk);
      elapsed++;
    end
    $display("Watchdog expired after %0d cycles, tests did not finish", elapsed);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
// Free-running 10 ns clock for the testbench; instantiate once in the testbench top.
`timescale 1ns/100ps
`default_nettype none

module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire
